//--- hw/coreCtrlPkg.sv
package coreCtrlPkg;

	// Operation selected for the execute datapath
	typedef enum logic [3:0]
	{
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd
	} aluOpT;

	// Iterative shifter sequencing
	typedef enum logic [1:0]
	{
		shiftIdle, // Loads operand and moves the first bit
		shiftShifting, // One bit per cycle
		shiftDone // Result goes to the register file
	} shiftStateT;

endpackage

//--- hw/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic rstN,
	input rvIsaPkg::instrT instr,
	input rvIsaPkg::addrT pc,
	input logic hazard,
	output rvIsaPkg::opcodeT opcode,
	output rvIsaPkg::func3T func3,
	output rvIsaPkg::func7T func7,
	output rvIsaPkg::regNumT rd,
	output rvIsaPkg::regNumT rs1,
	output rvIsaPkg::regNumT rs2,
	output rvIsaPkg::dataT imm,
	output rvIsaPkg::addrT instrPc
);

	rvIsaPkg::opcodeT instrOpcode;
	rvIsaPkg::func3T instrFunc3;
	rvIsaPkg::dataT instrImm;
	logic isShiftImm;

	assign instrOpcode = instr[6:0];
	assign instrFunc3 = instr[14:12];
	assign isShiftImm = (instrOpcode == rvIsaPkg::opcodeOpImm)
		&& (instrFunc3 == rvIsaPkg::func3Sll || instrFunc3 == rvIsaPkg::func3Sr);

	// Immediate by instruction format
	always_comb
	begin
		case (instrOpcode)
			rvIsaPkg::opcodeOpImm, rvIsaPkg::opcodeJalr, rvIsaPkg::opcodeLoad:
				if (isShiftImm)
					instrImm = {20'b0, instr[31:20]}; // shamt plus func7 bits
				else
					instrImm = {{20{instr[31]}}, instr[31:20]};
			rvIsaPkg::opcodeStore:
				instrImm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			rvIsaPkg::opcodeBranch:
				instrImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			rvIsaPkg::opcodeLui, rvIsaPkg::opcodeAuipc:
				instrImm = {instr[31:12], 12'b0};
			rvIsaPkg::opcodeJal:
				instrImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			default:
				instrImm = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			opcode <= rvIsaPkg::opcodeOpImm; // NOP
			func3 <= '0;
			func7 <= '0;
			rd <= '0;
			rs1 <= '0;
			rs2 <= '0;
			imm <= '0;
			instrPc <= '0;
		end
		else if (!hazard)
		begin
			opcode <= instrOpcode;
			func3 <= instrFunc3;
			func7 <= instr[31:25];
			rd <= instr[11:7];
			rs1 <= instr[19:15];
			rs2 <= instr[24:20];
			imm <= instrImm;
			instrPc <= pc;
		end
	end

endmodule

//--- hw/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic rstN,
	input rvIsaPkg::opcodeT opcode,
	input rvIsaPkg::func3T func3,
	input rvIsaPkg::func7T func7,
	input rvIsaPkg::regNumT rd,
	input rvIsaPkg::regNumT rs1,
	input rvIsaPkg::regNumT rs2,
	input rvIsaPkg::dataT imm,
	input rvIsaPkg::addrT instrPc,
	input logic flush,
	input rvIsaPkg::dataT rs1Data,
	input rvIsaPkg::dataT rs2Data,
	output rvIsaPkg::addrT pcWriteData,
	output logic pcWriteEnable,
	output logic hazard,
	output logic regWe,
	output rvIsaPkg::regNumT regWriteNum,
	output rvIsaPkg::dataT regWriteData,
	output logic retireValid,
	output rvIsaPkg::regNumT retireRegNum,
	output rvIsaPkg::dataT retireData
);

	logic instrValid, isShift, shiftBusy, writesRd, branchTaken;
	logic equal, lessSigned, lessUnsigned;
	logic [4:0] shamt, shiftCount;
	rvIsaPkg::dataT opB, pcPlusImm, jalrSum, aluResult, shiftReg;
	coreCtrlPkg::aluOpT aluOp;
	coreCtrlPkg::shiftStateT shiftState;

	// One bit of SLL, SRL or SRA
	function automatic rvIsaPkg::dataT shiftStep(input rvIsaPkg::dataT value,
		input coreCtrlPkg::aluOpT op);
		case (op)
			coreCtrlPkg::aluSll: shiftStep = {value[30:0], 1'b0};
			coreCtrlPkg::aluSra: shiftStep = {value[31], value[31:1]}; // Sign fill
			default: shiftStep = {1'b0, value[31:1]};
		endcase
	endfunction

	assign instrValid = !flush; // Wrong-path slot after a redirect
	assign opB = (opcode == rvIsaPkg::opcodeOp || opcode == rvIsaPkg::opcodeBranch)
		? rs2Data : imm;
	assign equal = (rs1Data == opB);
	assign lessSigned = ($signed(rs1Data) < $signed(opB));
	assign lessUnsigned = (rs1Data < opB);
	assign pcPlusImm = instrPc + imm;
	assign jalrSum = rs1Data + imm;

	assign isShift = (opcode == rvIsaPkg::opcodeOpImm || opcode == rvIsaPkg::opcodeOp)
		&& (func3 == rvIsaPkg::func3Sll || func3 == rvIsaPkg::func3Sr);
	// Shifting x0 is zero whatever the amount, so it finishes at once
	assign shamt = (rs1 == '0) ? 5'd0
		: (opcode == rvIsaPkg::opcodeOp) ? rs2Data[4:0] : rs2;

	always_comb
	begin
		case (func3)
			rvIsaPkg::func3Add:
				aluOp = (opcode == rvIsaPkg::opcodeOp && func7[5])
					? coreCtrlPkg::aluSub : coreCtrlPkg::aluAdd;
			rvIsaPkg::func3Sll: aluOp = coreCtrlPkg::aluSll;
			rvIsaPkg::func3Slt: aluOp = coreCtrlPkg::aluSlt;
			rvIsaPkg::func3Sltu: aluOp = coreCtrlPkg::aluSltu;
			rvIsaPkg::func3Xor: aluOp = coreCtrlPkg::aluXor;
			rvIsaPkg::func3Sr: aluOp = func7[5] ? coreCtrlPkg::aluSra : coreCtrlPkg::aluSrl;
			rvIsaPkg::func3Or: aluOp = coreCtrlPkg::aluOr;
			default: aluOp = coreCtrlPkg::aluAnd;
		endcase
	end

	always_comb
	begin
		case (aluOp)
			coreCtrlPkg::aluAdd: aluResult = rs1Data + opB;
			coreCtrlPkg::aluSub: aluResult = rs1Data - opB;
			coreCtrlPkg::aluSlt: aluResult = {31'b0, lessSigned};
			coreCtrlPkg::aluSltu: aluResult = {31'b0, lessUnsigned};
			coreCtrlPkg::aluXor: aluResult = rs1Data ^ opB;
			coreCtrlPkg::aluOr: aluResult = rs1Data | opB;
			coreCtrlPkg::aluAnd: aluResult = rs1Data & opB;
			default: aluResult = (shiftState == coreCtrlPkg::shiftDone) ? shiftReg : rs1Data;
		endcase
	end

	always_comb
	begin
		case (func3)
			rvIsaPkg::func3Beq: branchTaken = equal;
			rvIsaPkg::func3Bne: branchTaken = !equal;
			rvIsaPkg::func3Blt: branchTaken = lessSigned;
			rvIsaPkg::func3Bge: branchTaken = !lessSigned;
			rvIsaPkg::func3Bltu: branchTaken = lessUnsigned;
			rvIsaPkg::func3Bgeu: branchTaken = !lessUnsigned;
			default: branchTaken = 1'b0;
		endcase
	end

	always_comb
	begin
		writesRd = 1'b1;
		case (opcode)
			rvIsaPkg::opcodeLui: regWriteData = imm;
			rvIsaPkg::opcodeAuipc: regWriteData = pcPlusImm;
			rvIsaPkg::opcodeJal, rvIsaPkg::opcodeJalr: regWriteData = instrPc + 32'd4; // Link
			rvIsaPkg::opcodeOpImm, rvIsaPkg::opcodeOp: regWriteData = aluResult;
			default:
			begin
				writesRd = 1'b0; // Branch, load, store and unknown
				regWriteData = aluResult;
			end
		endcase
	end

	assign shiftBusy = instrValid && isShift
		&& (shiftState == coreCtrlPkg::shiftShifting
		|| (shiftState == coreCtrlPkg::shiftIdle && shamt != 5'd0));
	assign hazard = shiftBusy;

	assign regWe = instrValid && writesRd && (rd != '0) && !shiftBusy;
	assign regWriteNum = rd;

	assign pcWriteEnable = instrValid && (opcode == rvIsaPkg::opcodeJal
		|| opcode == rvIsaPkg::opcodeJalr
		|| (opcode == rvIsaPkg::opcodeBranch && branchTaken));
	assign pcWriteData = (opcode == rvIsaPkg::opcodeJalr) ? {jalrSum[31:1], 1'b0} : pcPlusImm;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			shiftState <= coreCtrlPkg::shiftIdle;
			shiftCount <= '0;
		end
		else
		begin
			case (shiftState)
				coreCtrlPkg::shiftIdle:
					if (shiftBusy)
					begin
						shiftCount <= shamt - 5'd1; // First bit moves on this edge
						if (shamt == 5'd1)
							shiftState <= coreCtrlPkg::shiftDone;
						else
							shiftState <= coreCtrlPkg::shiftShifting;
					end
				coreCtrlPkg::shiftShifting:
				begin
					shiftCount <= shiftCount - 5'd1;
					if (shiftCount == 5'd1)
						shiftState <= coreCtrlPkg::shiftDone;
				end
				default:
					shiftState <= coreCtrlPkg::shiftIdle; // Written this cycle
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (shiftState == coreCtrlPkg::shiftIdle)
			shiftReg <= shiftStep(rs1Data, aluOp);
		else if (shiftState == coreCtrlPkg::shiftShifting)
			shiftReg <= shiftStep(shiftReg, aluOp);
	end

	// Retire report is the write seen one edge later
	always_ff @(posedge clk)
	begin
		if (!rstN)
			retireValid <= 1'b0;
		else
			retireValid <= regWe;
	end

	always_ff @(posedge clk)
	begin
		retireRegNum <= regWriteNum;
		retireData <= regWriteData;
	end

endmodule

//--- hw/instrFetch.sv
`timescale 1ns/1ps

module instrFetch #(
	parameter int imemAddrBits = 6
) (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic imemWe,
	input logic [imemAddrBits-1:0] imemAddr,
	input rvIsaPkg::instrT imemData,
	input logic hazard,
	input logic pcWriteEnable,
	input rvIsaPkg::addrT pcWriteData,
	output rvIsaPkg::instrT instr,
	output rvIsaPkg::addrT pc,
	output logic flush
);

	rvIsaPkg::instrT imem [2**imemAddrBits];

	// Program load port used while the core is stopped
	always_ff @(posedge clk)
	begin
		if (imemWe && !run)
			imem[imemAddr] <= imemData;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			pc <= '0;
			flush <= 1'b0;
		end
		else
		begin
			flush <= pcWriteEnable; // Drops the wrong-path instruction
			if (!run)
				pc <= '0;
			else if (pcWriteEnable)
				pc <= pcWriteData; // Taken branch or jump
			else if (!hazard)
				pc <= pc + 32'd4;
		end
	end

	// A stopped core sees ADDI x0, x0, 0 so decode fills with bubbles
	assign instr = run ? imem[pc[imemAddrBits+1:2]] : {25'b0, rvIsaPkg::opcodeOpImm};

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rstN,
	input rvIsaPkg::regNumT rs1,
	input rvIsaPkg::regNumT rs2,
	output rvIsaPkg::dataT rs1Data,
	output rvIsaPkg::dataT rs2Data,
	input logic regWe,
	input rvIsaPkg::regNumT regWriteNum,
	input rvIsaPkg::dataT regWriteData
);

	localparam int regCount = 2**rvIsaPkg::regNumBits;

	rvIsaPkg::dataT regs [regCount];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end
		else if (regWe && regWriteNum != '0)
			regs[regWriteNum] <= regWriteData;
	end

	// x0 is always zero
	assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hw/rvCoreTop.sv
`timescale 1ns/1ps

module rvCoreTop #(
	parameter int imemAddrBits = 6
) (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic imemWe,
	input logic [imemAddrBits-1:0] imemAddr,
	input rvIsaPkg::instrT imemData,
	output logic retireValid,
	output rvIsaPkg::regNumT retireRegNum,
	output rvIsaPkg::dataT retireData
);

	rvIsaPkg::instrT instr;
	rvIsaPkg::addrT pc, instrPc, pcWriteData;
	rvIsaPkg::opcodeT opcode;
	rvIsaPkg::func3T func3;
	rvIsaPkg::func7T func7;
	rvIsaPkg::regNumT rd, rs1, rs2, regWriteNum;
	rvIsaPkg::dataT imm, rs1Data, rs2Data, regWriteData;
	logic hazard, flush, pcWriteEnable, regWe;

	instrFetch #(
		.imemAddrBits(imemAddrBits)
	) fetch (
		.clk(clk), .rstN(rstN), .run(run),
		.imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.hazard(hazard), .pcWriteEnable(pcWriteEnable), .pcWriteData(pcWriteData),
		.instr(instr), .pc(pc), .flush(flush)
	);

	decodeStage decode (
		.clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .hazard(hazard),
		.opcode(opcode), .func3(func3), .func7(func7),
		.rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .instrPc(instrPc)
	);

	// Register indices come straight from the decode register
	regFile regs (
		.clk(clk), .rstN(rstN),
		.rs1(rs1), .rs2(rs2), .rs1Data(rs1Data), .rs2Data(rs2Data),
		.regWe(regWe), .regWriteNum(regWriteNum), .regWriteData(regWriteData)
	);

	executeStage execute (
		.clk(clk), .rstN(rstN),
		.opcode(opcode), .func3(func3), .func7(func7),
		.rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .instrPc(instrPc),
		.flush(flush), .rs1Data(rs1Data), .rs2Data(rs2Data),
		.pcWriteData(pcWriteData), .pcWriteEnable(pcWriteEnable), .hazard(hazard),
		.regWe(regWe), .regWriteNum(regWriteNum), .regWriteData(regWriteData),
		.retireValid(retireValid), .retireRegNum(retireRegNum), .retireData(retireData)
	);

endmodule

//--- hw/rvIsaPkg.sv
package rvIsaPkg;

	// Base widths of the RV32I encoding
	localparam int xlen = 32;
	localparam int regNumBits = 5;
	localparam int opcodeBits = 7;
	localparam int func3Bits = 3;
	localparam int func7Bits = 7;

	typedef logic [xlen-1:0] instrT;
	typedef logic [xlen-1:0] addrT; // Byte address
	typedef logic [xlen-1:0] dataT;
	typedef logic [regNumBits-1:0] regNumT;
	typedef logic [opcodeBits-1:0] opcodeT;
	typedef logic [func3Bits-1:0] func3T;
	typedef logic [func7Bits-1:0] func7T;

	// Major opcodes
	localparam opcodeT opcodeOpImm = 7'b0010011;
	localparam opcodeT opcodeOp = 7'b0110011;
	localparam opcodeT opcodeLui = 7'b0110111;
	localparam opcodeT opcodeAuipc = 7'b0010111;
	localparam opcodeT opcodeJal = 7'b1101111;
	localparam opcodeT opcodeJalr = 7'b1100111;
	localparam opcodeT opcodeBranch = 7'b1100011;
	localparam opcodeT opcodeLoad = 7'b0000011;
	localparam opcodeT opcodeStore = 7'b0100011;

	// func3 of OP and OP_IMM
	localparam func3T func3Add = 3'b000; // SUB when func7[5] set on OP
	localparam func3T func3Sll = 3'b001;
	localparam func3T func3Slt = 3'b010;
	localparam func3T func3Sltu = 3'b011;
	localparam func3T func3Xor = 3'b100;
	localparam func3T func3Sr = 3'b101; // SRA when func7[5] set
	localparam func3T func3Or = 3'b110;
	localparam func3T func3And = 3'b111;

	// func3 of BRANCH
	localparam func3T func3Beq = 3'b000;
	localparam func3T func3Bne = 3'b001;
	localparam func3T func3Blt = 3'b100;
	localparam func3T func3Bge = 3'b101;
	localparam func3T func3Bltu = 3'b110;
	localparam func3T func3Bgeu = 3'b111;

endpackage

//--- sim/coreTb.sv
`timescale 1ns/1ps

module coreTb;

	localparam int imemAddrBits = 6;
	localparam int fileWords = 128;
	localparam int retireTimeout = 200; // Cycles per retire, well above the longest shift
	localparam int quietCycles = 100;

	logic clk;
	logic rstN;
	logic run;
	logic imemWe;
	logic [imemAddrBits-1:0] imemAddr;
	rvIsaPkg::instrT imemData;
	logic retireValid;
	rvIsaPkg::regNumT retireRegNum;
	rvIsaPkg::dataT retireData;

	logic [31:0] fileData [fileWords]; // Count, program, count, records
	int errorCount;
	int timeoutCount;
	int progWords;
	int retireCount;

	rvCoreTop #(
		.imemAddrBits(imemAddrBits)
	) DUT (
		.clk(clk), .rstN(rstN), .run(run),
		.imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.retireValid(retireValid), .retireRegNum(retireRegNum), .retireData(retireData)
	);

	always #50 clk = ~clk;

	// One word per cycle while the core is stopped
	task automatic loadProgram();
		for (int i = 0; i < progWords; i++)
		begin
			@(negedge clk);
			imemWe = 1'b1;
			imemAddr = i[imemAddrBits-1:0];
			imemData = fileData[i + 1];
		end
		@(negedge clk);
		imemWe = 1'b0;
	endtask

	task automatic waitRetire(output bit seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < retireTimeout)
		begin
			@(negedge clk);
			if (retireValid)
				seen = 1'b1;
			cycles++;
		end
	endtask

	task automatic checkRetire(input int index);
		rvIsaPkg::regNumT expReg;
		rvIsaPkg::dataT expData;
		expReg = fileData[progWords + 2 + 2 * index][4:0];
		expData = fileData[progWords + 3 + 2 * index];
		assert (retireRegNum == expReg)
		else
		begin
			$display("CHECK FAILED retireRegNum (retire %0d): expected 0x%h, got 0x%h",
				index, expReg, retireRegNum);
			errorCount++;
		end
		assert (retireData == expData)
		else
		begin
			$display("CHECK FAILED retireData (retire %0d): expected 0x%h, got 0x%h",
				index, expData, retireData);
			errorCount++;
		end
	endtask

	// Core sits in the final self-loop where nothing may retire
	task automatic checkQuiet();
		for (int i = 0; i < quietCycles; i++)
		begin
			@(negedge clk);
			assert (!retireValid)
			else
			begin
				$display("CHECK FAILED retireValid (quiet cycle %0d): expected 0x0, got 0x%h",
					i, retireValid);
				errorCount++;
			end
		end
	endtask

	initial
	begin
		bit seen;
		clk = 1'b0;
		rstN = 1'b0;
		run = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		errorCount = 0;
		timeoutCount = 0;
		$readmemh("sim/programInput.txt", fileData);
		progWords = fileData[0];
		retireCount = fileData[progWords + 1];
		repeat (5) @(negedge clk);
		rstN = 1'b1;
		loadProgram();
		run = 1'b1;
		for (int i = 0; i < retireCount && timeoutCount == 0; i++)
		begin
			waitRetire(seen);
			if (seen)
				checkRetire(i);
			else
			begin
				$display("Timed out waiting for retire %0d of %0d", i, retireCount);
				timeoutCount++;
			end
		end
		if (timeoutCount == 0)
			checkQuiet();
		$display("Errors: %0d failed checks, %0d timeouts", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- sim/programInput.txt
// Word count, then the program words, four per line (byte address in the comment)
// Retire count, then one record per retire: register number, register value
2F
FFB00093 FFC0A113 0050B193 7FF0C213 // 00 ADDI SLTI SLTIU XORI
F0006293 FF027313 123453B7 00001417 // 10 ORI ANDI LUI AUIPC
007404B3 40148533 00A0A5B3 0015B633 // 20 ADD SUB SLT SLTU
007666B3 0066F733 001747B3 00009813 // 30 OR AND XOR SLLI by 0
00185893 41F0D913 00290993 01F00A13 // 40 SRLI by 1, SRAI by 31, ADDI after shift
01499AB3 413ADB33 000B5BB3 014B5C33 // 50 SLL by 31, SRA by 1, SRL by 0, SRL by 31
018C0CB3 00508013 01900D33 01AC8463 // 60 ADD, ADDI to x0, ADD from x0, BEQ taken
00100F93 01AC9463 00700D93 0130C463 // 70 wrong path, BNE not taken, ADDI, BLT taken
00100F93 0130D463 001D8D93 0130E463 // 80 wrong path, BGE not taken, ADDI, BLTU not taken
001D8D93 0130F463 00100F93 00800E6F // 90 ADDI, BGEU taken, wrong path, JAL x28
00100F93 011E0EE7 00100F93 00100F93 // A0 wrong path, JALR x29 to B0, two skipped
01FE8F33 0000006F 00000013          // B0 ADD x30 from x31, self-loop, NOP
20
01 FFFFFFFB 02 00000001 03 00000000 04 FFFFF804
05 FFFFFF00 06 FFFFF800 07 12345000 08 0000101C
09 1234601C 0A 12346021 0B 00000001 0C 00000001
0D 12345001 0E 12345000 0F EDCBAFFB 10 FFFFFFFB
11 7FFFFFFD 12 FFFFFFFF 13 00000001 14 0000001F
15 80000000 16 C0000000 17 C0000000 18 00000001
19 00000002 1A 00000002 1B 00000007 1B 00000008
1B 00000009 1C 000000A0 1D 000000A8 1E 000000A8

//--- sources.f
hw/rvIsaPkg.sv
hw/coreCtrlPkg.sv
hw/regFile.sv
hw/instrFetch.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/rvCoreTop.sv
sim/coreTb.sv
